// ==== Makefile ====
# Verilator build and run of the arithmetic unit testbench

TOP := aluTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o V$(TOP)

# The run passes only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
rtl/aluPkg.sv
rtl/addSubUnit.sv
rtl/arrayMultiplier.sv
rtl/restoringDivider.sv
rtl/aluCore.sv
rtl/wbAluSlave.sv
rtl/aluTop.sv
testbench/aluTb.sv

// ==== rtl/addSubUnit.sv ====
// Ripple-carry adder-subtractor for the arithmetic core
// subtract low gives the unsigned sum, high gives the two's complement difference
`timescale 1ns/10ps
`default_nettype none

module addSubUnit #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic [Width-1:0]           a,
	input  logic [Width-1:0]           b,
	input  logic                       subtract,
	output logic [aluPkg::busWidth-1:0] result,
	output logic                       overflow
);
	import aluPkg::*;

	logic [Width-1:0] bInv;
	logic [Width-1:0] sum;
	logic [Width:0]   carry;
	logic             topBit;
	logic             signExt;

	// Invert b and inject a carry for subtraction
	assign bInv     = b ^ {Width{subtract}};
	assign carry[0] = subtract;

	// ========================================
	// Full-adder chain
	// ========================================
	for (genvar k = 0; k < Width; k++) begin : genFullAdder
		assign sum[k]     = a[k] ^ bInv[k] ^ carry[k];
		assign carry[k+1] = (a[k] & bInv[k]) | (carry[k] & (a[k] ^ bInv[k]));
	end

	// Carry out is bit Width of the sum; for subtraction a missing
	// carry means a borrow, so the bit is inverted and becomes the sign
	assign topBit  = carry[Width] ^ subtract;
	assign signExt = topBit & subtract;

	assign result = {{(busWidth-Width-1){signExt}}, topBit, sum};

	// Signed overflow from the last two carries
	assign overflow = carry[Width] ^ carry[Width-1];

endmodule

`default_nettype wire

// ==== rtl/aluCore.sv ====
// Arithmetic core: add, subtract, multiply, divide and modulo
// Purely combinational; result and flags are selected by the opcode
`timescale 1ns/10ps
`default_nettype none

module aluCore #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic [Width-1:0]            operandA,
	input  logic [Width-1:0]            operandB,
	input  aluPkg::aluOp_t              opcode,
	output logic [aluPkg::busWidth-1:0] result,
	output logic                        overflow,
	output logic                        zeroDiv
);
	import aluPkg::*;

	logic [busWidth-1:0] sumWide;
	logic [busWidth-1:0] diffWide;
	logic [busWidth-1:0] productWide;
	logic                addOverflow;
	logic [Width-1:0]    quotient;
	logic [Width-1:0]    remainder;
	logic                divByZero;

	// ========================================
	// Arithmetic units
	// ========================================
	addSubUnit #(.Width(Width)) adder (
		.a        (operandA),
		.b        (operandB),
		.subtract (1'b0),
		.result   (sumWide),
		.overflow (addOverflow)
	);

	// Overflow of the difference is not reported
	addSubUnit #(.Width(Width)) subtractor (
		.a        (operandA),
		.b        (operandB),
		.subtract (1'b1),
		.result   (diffWide),
		.overflow ()
	);

	arrayMultiplier #(.Width(Width)) multiplier (
		.a       (operandA),
		.b       (operandB),
		.product (productWide)
	);

	restoringDivider #(.Width(Width)) divider (
		.dividend    (operandA),
		.divisor     (operandB),
		.quotient    (quotient),
		.remainder   (remainder),
		.zeroDivisor (divByZero)
	);

	// ========================================
	// Result select
	// ========================================
	always_comb begin
		result   = '0;
		overflow = 1'b0;
		zeroDiv  = 1'b0;
		case (opcode)
			opAdd: begin
				result   = sumWide;
				overflow = addOverflow;
			end
			opSub: result = diffWide;
			opMul: result = productWide;
			opDiv: begin
				result  = busWidth'(quotient);
				zeroDiv = divByZero;
			end
			opMod: begin
				result  = busWidth'(remainder);
				zeroDiv = divByZero;
			end
			// Unused codes keep the zero defaults
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/aluPkg.sv ====
// Shared widths, opcodes and register map of the Wishbone arithmetic unit
// Modules import it inside their bodies and use scoped names in their headers
`default_nettype none

package aluPkg;

	// ========================================
	// Widths
	// ========================================
	// Operand width, one word
	localparam int dataWidth = 16;
	// Bus data width, wide enough for a full product
	localparam int busWidth = 32;
	// Word address width of the register map
	localparam int addrWidth = 3;

	// ========================================
	// Opcodes and register map
	// ========================================
	// Codes 5 to 15 are unused and give a zero result
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opMul = 4'd2,
		opDiv = 4'd3,
		opMod = 4'd4
	} aluOp_t;

	typedef enum logic [addrWidth-1:0] {
		regOperandA = 3'd0,
		regOperandB = 3'd1,
		regOpcode   = 3'd2,
		regResult   = 3'd3,
		regStatus   = 3'd4
	} regAddr_t;

	// Bit positions in the status word
	localparam int statusOverflowBit = 0;
	localparam int statusZeroDivBit  = 1;

endpackage

`default_nettype wire

// ==== rtl/aluTop.sv ====
// Top level of the Wishbone arithmetic unit
// Connects the bus slave registers to the combinational core
`timescale 1ns/10ps
`default_nettype none

module aluTop #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         cyc,
	input  logic                         stb,
	input  logic                         we,
	input  logic [aluPkg::addrWidth-1:0] adr,
	input  logic [aluPkg::busWidth-1:0]  datWr,
	output logic [aluPkg::busWidth-1:0]  datRd,
	output logic                         ack
);
	import aluPkg::*;

	logic [Width-1:0]    operandA;
	logic [Width-1:0]    operandB;
	aluOp_t              opcode;
	logic [busWidth-1:0] result;
	logic                overflow;
	logic                zeroDiv;

	wbAluSlave #(.Width(Width)) slave (
		.clk      (clk),
		.rstN     (rstN),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.datWr    (datWr),
		.datRd    (datRd),
		.ack      (ack),
		.operandA (operandA),
		.operandB (operandB),
		.opcode   (opcode),
		.result   (result),
		.overflow (overflow),
		.zeroDiv  (zeroDiv)
	);

	aluCore #(.Width(Width)) core (
		.operandA (operandA),
		.operandB (operandB),
		.opcode   (opcode),
		.result   (result),
		.overflow (overflow),
		.zeroDiv  (zeroDiv)
	);

endmodule

`default_nettype wire

// ==== rtl/arrayMultiplier.sv ====
// Unsigned array multiplier built from rows of ripple adders
// Each row adds one AND partial product into the shifted sum of the row above
`timescale 1ns/10ps
`default_nettype none

module arrayMultiplier #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic [Width-1:0]            a,
	input  logic [Width-1:0]            b,
	output logic [aluPkg::busWidth-1:0] product
);
	import aluPkg::*;

	logic [Width-1:0]   partial [Width];
	logic [Width-1:0]   rowSum [Width];
	logic               rowCarry [Width];
	logic [Width-1:0]   lowBits;
	logic [2*Width-1:0] fullProduct;

	// One partial product per bit of b
	for (genvar r = 0; r < Width; r++) begin : genPartial
		assign partial[r] = a & {Width{b[r]}};
	end

	// First row passes straight through
	assign rowSum[0]   = partial[0];
	assign rowCarry[0] = 1'b0;
	assign lowBits[0]  = rowSum[0][0];

	// ========================================
	// Adder rows
	// ========================================
	for (genvar r = 1; r < Width; r++) begin : genRow
		logic [Width-1:0] augend;
		logic [Width:0]   carry;

		// Previous sum shifted down by one, with its carry on top
		assign augend   = {rowCarry[r-1], rowSum[r-1][Width-1:1]};
		assign carry[0] = 1'b0;

		for (genvar k = 0; k < Width; k++) begin : genBit
			assign rowSum[r][k] = augend[k] ^ partial[r][k] ^ carry[k];
			assign carry[k+1]   = (augend[k] & partial[r][k]) |
				(carry[k] & (augend[k] ^ partial[r][k]));
		end

		assign rowCarry[r] = carry[Width];
		// Bit 0 of each row is final once the row settles
		assign lowBits[r]  = rowSum[r][0];
	end

	// Last row supplies the upper half
	assign fullProduct = {rowCarry[Width-1], rowSum[Width-1][Width-1:1], lowBits};
	assign product     = busWidth'(fullProduct);

endmodule

`default_nettype wire

// ==== rtl/restoringDivider.sv ====
// Combinational restoring divider shared by divide and modulo
// A zero divisor yields an all-ones quotient and the dividend as remainder
`timescale 1ns/10ps
`default_nettype none

module restoringDivider #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic [Width-1:0] dividend,
	input  logic [Width-1:0] divisor,
	output logic [Width-1:0] quotient,
	output logic [Width-1:0] remainder,
	output logic             zeroDivisor
);

	logic [Width-1:0] partRem [Width+1];

	assign partRem[0] = '0;

	// ========================================
	// Trial-subtract stages, MSB first
	// ========================================
	for (genvar i = 0; i < Width; i++) begin : genStage
		logic [Width:0]   shifted;
		logic [Width+1:0] diff;
		logic             fits;

		// Bring down the next dividend bit
		assign shifted = {partRem[i], dividend[Width-1-i]};
		assign diff    = {1'b0, shifted} - {2'b00, divisor};

		// No borrow means the divisor fits at this position
		assign fits = ~diff[Width+1];

		assign quotient[Width-1-i] = fits;
		// Restore the shifted value when the subtraction went negative
		assign partRem[i+1] = fits ? diff[Width-1:0] : shifted[Width-1:0];
	end

	assign remainder   = partRem[Width];
	assign zeroDivisor = ~|divisor;

endmodule

`default_nettype wire

// ==== rtl/wbAluSlave.sv ====
// Wishbone classic slave holding the operand and opcode registers
// Every request is acked one cycle later; read data is registered with the ack
`timescale 1ns/10ps
`default_nettype none

module wbAluSlave #(
	parameter int Width = aluPkg::dataWidth
) (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         cyc,
	input  logic                         stb,
	input  logic                         we,
	input  logic [aluPkg::addrWidth-1:0] adr,
	input  logic [aluPkg::busWidth-1:0]  datWr,
	output logic [aluPkg::busWidth-1:0]  datRd,
	output logic                         ack,
	output logic [Width-1:0]             operandA,
	output logic [Width-1:0]             operandB,
	output aluPkg::aluOp_t               opcode,
	input  logic [aluPkg::busWidth-1:0]  result,
	input  logic                         overflow,
	input  logic                         zeroDiv
);
	import aluPkg::*;

	logic                request;
	regAddr_t            addrSel;
	logic [busWidth-1:0] readData;

	// New request only once the previous ack has dropped
	assign request = cyc & stb & ~ack;
	assign addrSel = regAddr_t'(adr);

	// ========================================
	// Ack and writable registers
	// ========================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ack      <= 1'b0;
			operandA <= '0;
			operandB <= '0;
			opcode   <= opAdd;
		end else begin
			ack <= request;
			if (request && we) begin
				case (addrSel)
					regOperandA: operandA <= datWr[Width-1:0];
					regOperandB: operandB <= datWr[Width-1:0];
					regOpcode:   opcode <= aluOp_t'(datWr[$bits(aluOp_t)-1:0]);
					// Result, status and unmapped words ignore writes
					default: ;
				endcase
			end
		end
	end

	// ========================================
	// Read path
	// ========================================
	always_comb begin
		readData = '0;
		case (addrSel)
			regOperandA: readData[Width-1:0] = operandA;
			regOperandB: readData[Width-1:0] = operandB;
			regOpcode:   readData[$bits(aluOp_t)-1:0] = opcode;
			regResult:   readData = result;
			regStatus: begin
				readData[statusOverflowBit] = overflow;
				readData[statusZeroDivBit]  = zeroDiv;
			end
			default: readData = '0;
		endcase
	end

	// Captured with the request so it is valid while ack is high
	always_ff @(posedge clk) begin
		if (request) begin
			datRd <= readData;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/aluTb.sv ====
// Testbench for the Wishbone arithmetic unit
// Drives register writes and reads over the bus and checks each result against a model
`timescale 1ns/10ps
`default_nettype none

module aluTb;
	import aluPkg::*;

	localparam int ackTimeout = 20;

	logic                 clk;
	logic                 rstN;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [addrWidth-1:0] adr;
	logic [busWidth-1:0]  datWr;
	logic [busWidth-1:0]  datRd;
	logic                 ack;
	logic [15:0]          lfsrState;

	aluTop #(.Width(dataWidth)) UUT (
		.clk   (clk),
		.rstN  (rstN),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.datWr (datWr),
		.datRd (datRd),
		.ack   (ack)
	);

	always #5 clk = ~clk;

	// ========================================
	// Error handling
	// ========================================
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [busWidth-1:0] got,
			input logic [busWidth-1:0] want);
		abortRun($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, want));
	endtask

	// Ack only follows a request and never stays high for two cycles
	assert property (@(posedge clk) disable iff (!rstN)
		ack |-> (!$past(ack) && $past(cyc && stb)))
		else abortRun("ack was high without a request in the cycle before");

	// ========================================
	// Stimulus helpers
	// ========================================
	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function logic [dataWidth-1:0] randomOperand();
		logic [dataWidth-1:0] value;
		value = '0;
		for (int i = 0; i < dataWidth; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[dataWidth-2:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic busWrite(input logic [addrWidth-1:0] addr, input logic [busWidth-1:0] data);
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = addr;
		datWr = data;
		do begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > ackTimeout) begin
				abortRun("No ack for a bus write within the timeout");
			end
		end while (!ack);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic busRead(input logic [addrWidth-1:0] addr, output logic [busWidth-1:0] data);
		int waitCycles;
		waitCycles = 0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = addr;
		do begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > ackTimeout) begin
				abortRun("No ack for a bus read within the timeout");
			end
		end while (!ack);
		data = datRd;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [busWidth-1:0] modelResult(input logic [3:0] op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [busWidth-1:0] wideA;
		logic [busWidth-1:0] wideB;
		wideA = {16'h0000, a};
		wideB = {16'h0000, b};
		case (op)
			opAdd: return wideA + wideB;
			opSub: return wideA - wideB;
			opMul: return wideA * wideB;
			opDiv: return (b == 0) ? 32'h0000_ffff : wideA / wideB;
			opMod: return (b == 0) ? wideA : wideA % wideB;
			default: return '0;
		endcase
	endfunction

	function automatic logic [busWidth-1:0] modelStatus(input logic [3:0] op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [busWidth-1:0] status;
		int signedA;
		int signedB;
		int signedSum;
		status = '0;
		signedA = $signed(a);
		signedB = $signed(b);
		signedSum = signedA + signedB;
		if (op == opAdd && (signedSum > 32767 || signedSum < -32768)) begin
			status[statusOverflowBit] = 1'b1;
		end
		if ((op == opDiv || op == opMod) && b == 0) begin
			status[statusZeroDivBit] = 1'b1;
		end
		return status;
	endfunction

	task automatic checkOperation(input logic [3:0] op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b);
		logic [busWidth-1:0] gotResult;
		logic [busWidth-1:0] gotStatus;
		busWrite(regOperandA, {16'h0000, a});
		busWrite(regOperandB, {16'h0000, b});
		busWrite(regOpcode, {28'h0, op});
		busRead(regResult, gotResult);
		busRead(regStatus, gotStatus);
		assert (gotResult == modelResult(op, a, b))
			else reportMismatch("result", gotResult, modelResult(op, a, b));
		assert (gotStatus == modelStatus(op, a, b))
			else reportMismatch("status", gotStatus, modelStatus(op, a, b));
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		logic [busWidth-1:0]  readValue;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		clk = 1'b0;
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		lfsrState = 16'd27643;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Every register reads zero out of reset
		for (int r = 0; r <= 4; r++) begin
			busRead(addrWidth'(r), readValue);
			assert (readValue == '0) else reportMismatch("datRd after reset", readValue, '0);
		end

		// Operands keep only their low word
		busWrite(regOperandA, 32'habcd_5678);
		busRead(regOperandA, readValue);
		assert (readValue == 32'h0000_5678) else reportMismatch("operandA", readValue, 32'h5678);

		// Additions and subtractions
		checkOperation(opAdd, 16'h7fff, 16'h0001);
		checkOperation(opAdd, 16'h8000, 16'h8000);
		checkOperation(opAdd, 16'hffff, 16'hffff);
		checkOperation(opAdd, 16'h0000, 16'h0000);
		for (int i = 0; i < 16; i++) begin
			checkOperation(opAdd, randomOperand(), randomOperand());
		end
		for (int i = 0; i < 12; i++) begin
			a = randomOperand();
			b = randomOperand();
			checkOperation(opSub, (a > b) ? a : b, (a > b) ? b : a);
			checkOperation(opSub, (a > b) ? b : a, (a > b) ? a : b);
		end

		// Multiplications
		checkOperation(opMul, 16'hffff, 16'hffff);
		for (int i = 0; i < 16; i++) begin
			checkOperation(opMul, randomOperand(), randomOperand());
		end

		// Division and modulo, with small divisors on odd passes
		for (int i = 0; i < 16; i++) begin
			a = randomOperand();
			b = randomOperand();
			if (i % 2 == 1) begin
				b = {8'h00, b[7:0]};
			end
			if (b == 0) begin
				b = 16'd1;
			end
			checkOperation(opDiv, a, b);
			checkOperation(opMod, a, b);
		end
		a = randomOperand();
		checkOperation(opDiv, a, 16'h0000);
		checkOperation(opMod, a, 16'h0000);
		checkOperation(opAdd, a, 16'h0000);

		// Unused opcodes
		for (int op = 5; op < 16; op++) begin
			checkOperation(4'(op), randomOperand(), randomOperand());
		end

		// Unmapped words read zero
		for (int r = 5; r < 8; r++) begin
			busRead(addrWidth'(r), readValue);
			assert (readValue == '0) else reportMismatch("datRd unmapped", readValue, '0);
		end

		// Result ignores writes, 0x1234 times 0xff stays in place
		checkOperation(opMul, 16'h1234, 16'h00ff);
		busWrite(regResult, 32'hdead_beef);
		busRead(regResult, readValue);
		assert (readValue == 32'h0012_21cc)
			else reportMismatch("result", readValue, 32'h0012_21cc);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
